/* common/mtap_pkg.sv */
// ****************************************
// mTAP shared definitions
// Widths, opcodes, IDCODE and state encodings
// ****************************************
`default_nettype none

package mtap_pkg;

   // Vector widths
   localparam int SECURE_WIDTH = 4;
   localparam int NUM_FEATURES = 3;
   localparam int IR_WIDTH     = 4;
   localparam int CTRL_WIDTH   = 8;
   localparam int DR_WIDTH     = 32;

   typedef logic [SECURE_WIDTH-1:0] secure_t;
   typedef logic [NUM_FEATURES-1:0] feature_t;
   typedef logic [IR_WIDTH-1:0]     ir_t;
   typedef logic [CTRL_WIDTH-1:0]   ctrl_t;
   typedef logic [DR_WIDTH-1:0]     dr_t;

   // Opcodes, anything not listed selects bypass
   localparam ir_t OP_IDCODE     = 4'h1;
   localparam ir_t OP_DEBUG_CTRL = 4'h8;
   localparam ir_t OP_SCAN_CFG   = 4'h9;
   localparam ir_t OP_BYPASS     = 4'hF;

   // Fixed IR capture pattern, low bits 01 per 1149.1
   localparam ir_t IR_CAPTURE = 4'b0001;

   // Device identification, bit 0 must be set
   localparam dr_t IDCODE_VALUE = 32'h0C8A_5013;

   // Feature slots in the enable vector
   localparam int FEATURE_DEBUG = 0;
   localparam int FEATURE_SCAN  = 2;

   // Strap code that unlocks the debug feature
   localparam logic [1:0] DEBUG_STRAP_CODE = 2'b01;

   // IEEE 1149.1 state encoding
   typedef enum logic [3:0] {
      exit2_dr         = 4'h0,
      exit1_dr         = 4'h1,
      shift_dr         = 4'h2,
      pause_dr         = 4'h3,
      select_ir_scan   = 4'h4,
      update_dr        = 4'h5,
      capture_dr       = 4'h6,
      select_dr_scan   = 4'h7,
      exit2_ir         = 4'h8,
      exit1_ir         = 4'h9,
      shift_ir         = 4'hA,
      pause_ir         = 4'hB,
      run_test_idle    = 4'hC,
      update_ir        = 4'hD,
      capture_ir       = 4'hE,
      test_logic_reset = 4'hF
   } tap_state_t;

   // Decoded instruction after security gating
   typedef enum logic [1:0] {
      instr_bypass,
      instr_idcode,
      instr_debug_ctrl,
      instr_scan_cfg
   } instr_t;

endpackage

`default_nettype wire

/* common/mtap_policy_if.sv */
// ****************************************
// mTAP policy bundle
// Decoded DFx security levels and enables
// ****************************************
`timescale 1ns/1ns
`default_nettype none

interface mtap_policy_if;

   // Policy extremes
   logic                 all_en;
   logic                 all_dis;

   // Per-feature enables after override
   mtap_pkg::feature_t   feature_en;

   // Visibility disables for observation logic
   logic                 vodfv_all_dis;
   logic                 vodfv_customer_dis;

   // Policy decoder side
   modport decoder (output all_en, all_dis, feature_en, vodfv_all_dis, vodfv_customer_dis);

   // Instruction gating side
   modport consumer (input feature_en);

endinterface

`default_nettype wire

/* compile.f */
common/mtap_pkg.sv
common/mtap_policy_if.sv
mtap/mtap_fsm.sv
mtap/mtap_ir.sv
mtap/mtap_dr.sv
source/mtap_dfxsecure.sv
source/mtap_top.sv
tests/tb_mtap.sv

/* mtap/mtap_dr.sv */
// ****************************************
// mTAP data registers
// Bypass, IDCODE, control registers and TDO
// ****************************************
`timescale 1ns/1ns
`default_nettype none

module mtap_dr
   (
   input  logic                   ftap_tck,
   input  logic                   reset,
   input  logic                   ftap_tdi,
   input  mtap_pkg::tap_state_t   state,
   input  mtap_pkg::instr_t       instr,
   input  logic                   ir_tdo,
   output mtap_pkg::ctrl_t        debug_ctrl,
   output mtap_pkg::ctrl_t        scan_cfg,
   output logic                   tdo
   );

   mtap_pkg::dr_t   dr_shift;
   mtap_pkg::dr_t   dr_next;
   logic            bypass_bit;

   // ****************************************
   // Shared shift stage
   // ****************************************
   // Insert point sets the chain length per instruction
   always_comb
   begin
      dr_next = dr_shift >> 1;
      case (instr)
         mtap_pkg::instr_idcode:
            dr_next[mtap_pkg::DR_WIDTH-1] = ftap_tdi;
         mtap_pkg::instr_debug_ctrl,
         mtap_pkg::instr_scan_cfg:
            dr_next[mtap_pkg::CTRL_WIDTH-1] = ftap_tdi;
         default:
            dr_next = dr_shift;
      endcase
   end

   always_ff @(posedge ftap_tck)
   begin
      if (state == mtap_pkg::capture_dr)
      begin
         case (instr)
            mtap_pkg::instr_idcode:     dr_shift <= mtap_pkg::IDCODE_VALUE;
            mtap_pkg::instr_debug_ctrl: dr_shift <= mtap_pkg::dr_t'(debug_ctrl);
            mtap_pkg::instr_scan_cfg:   dr_shift <= mtap_pkg::dr_t'(scan_cfg);
            default:                    dr_shift <= '0;
         endcase
      end
      else if (state == mtap_pkg::shift_dr)
         dr_shift <= dr_next;
   end

   // Single-bit bypass path, captures 0
   always_ff @(posedge ftap_tck)
   begin
      if (state == mtap_pkg::capture_dr)
         bypass_bit <= 1'b0;
      else if (state == mtap_pkg::shift_dr)
         bypass_bit <= ftap_tdi;
   end

   // ****************************************
   // Control registers
   // ****************************************
   // Only the reset pin clears these, TMS reset keeps them
   always_ff @(posedge ftap_tck)
   begin
      if (reset)
      begin
         debug_ctrl <= '0;
         scan_cfg   <= '0;
      end
      else if (state == mtap_pkg::update_dr)
      begin
         if (instr == mtap_pkg::instr_debug_ctrl)
            debug_ctrl <= dr_shift[mtap_pkg::CTRL_WIDTH-1:0];
         if (instr == mtap_pkg::instr_scan_cfg)
            scan_cfg <= dr_shift[mtap_pkg::CTRL_WIDTH-1:0];
      end
   end

   // TDO mux, low outside the shift states
   always_comb
   begin
      case (state)
         mtap_pkg::shift_ir: tdo = ir_tdo;
         mtap_pkg::shift_dr: tdo = (instr == mtap_pkg::instr_bypass) ? bypass_bit : dr_shift[0];
         default:            tdo = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

/* mtap/mtap_fsm.sv */
// ****************************************
// mTAP TAP controller
// Sixteen-state 1149.1 FSM driven by TMS
// ****************************************
`timescale 1ns/1ns
`default_nettype none

module mtap_fsm
   (
   input  logic                   ftap_tck,
   input  logic                   reset,
   input  logic                   ftap_tms,
   output mtap_pkg::tap_state_t   state
   );

   mtap_pkg::tap_state_t next_state;

   // ****************************************
   // Next state
   // ****************************************
   always_comb
   begin
      next_state = state;
      case (state)
         mtap_pkg::test_logic_reset:
            next_state = ftap_tms ? mtap_pkg::test_logic_reset : mtap_pkg::run_test_idle;
         mtap_pkg::run_test_idle:
            next_state = ftap_tms ? mtap_pkg::select_dr_scan : mtap_pkg::run_test_idle;
         // DR column
         mtap_pkg::select_dr_scan:
            next_state = ftap_tms ? mtap_pkg::select_ir_scan : mtap_pkg::capture_dr;
         mtap_pkg::capture_dr:
            next_state = ftap_tms ? mtap_pkg::exit1_dr : mtap_pkg::shift_dr;
         mtap_pkg::shift_dr:
            next_state = ftap_tms ? mtap_pkg::exit1_dr : mtap_pkg::shift_dr;
         mtap_pkg::exit1_dr:
            next_state = ftap_tms ? mtap_pkg::update_dr : mtap_pkg::pause_dr;
         mtap_pkg::pause_dr:
            next_state = ftap_tms ? mtap_pkg::exit2_dr : mtap_pkg::pause_dr;
         mtap_pkg::exit2_dr:
            next_state = ftap_tms ? mtap_pkg::update_dr : mtap_pkg::shift_dr;
         mtap_pkg::update_dr:
            next_state = ftap_tms ? mtap_pkg::select_dr_scan : mtap_pkg::run_test_idle;
         // IR column, mirrors the DR side
         mtap_pkg::select_ir_scan:
            next_state = ftap_tms ? mtap_pkg::test_logic_reset : mtap_pkg::capture_ir;
         mtap_pkg::capture_ir:
            next_state = ftap_tms ? mtap_pkg::exit1_ir : mtap_pkg::shift_ir;
         mtap_pkg::shift_ir:
            next_state = ftap_tms ? mtap_pkg::exit1_ir : mtap_pkg::shift_ir;
         mtap_pkg::exit1_ir:
            next_state = ftap_tms ? mtap_pkg::update_ir : mtap_pkg::pause_ir;
         mtap_pkg::pause_ir:
            next_state = ftap_tms ? mtap_pkg::exit2_ir : mtap_pkg::pause_ir;
         mtap_pkg::exit2_ir:
            next_state = ftap_tms ? mtap_pkg::update_ir : mtap_pkg::shift_ir;
         mtap_pkg::update_ir:
            next_state = ftap_tms ? mtap_pkg::select_dr_scan : mtap_pkg::run_test_idle;
         default:
            next_state = mtap_pkg::test_logic_reset;
      endcase
   end

   // State register, five TMS-high edges also land in reset
   always_ff @(posedge ftap_tck)
   begin
      if (reset)
         state <= mtap_pkg::test_logic_reset;
      else
         state <= next_state;
   end

   // Every 4-bit code is a state, so only an unknown value is illegal
   assert property (@(posedge ftap_tck) disable iff (reset) !$isunknown(state));

endmodule

`default_nettype wire

/* mtap/mtap_ir.sv */
// ****************************************
// mTAP instruction register
// IR shift, update and secure decode
// ****************************************
`timescale 1ns/1ns
`default_nettype none

module mtap_ir
   (
   input  logic                   ftap_tck,
   input  logic                   reset,
   input  logic                   ftap_tdi,
   input  mtap_pkg::tap_state_t   state,
   mtap_policy_if.consumer        policy,
   output mtap_pkg::instr_t       instr,
   output logic                   ir_tdo
   );

   mtap_pkg::ir_t      ir_shift;
   mtap_pkg::instr_t   decoded;

   // ****************************************
   // Shift stage
   // ****************************************
   // New bit enters at the top, LSB leaves first
   always_ff @(posedge ftap_tck)
   begin
      if (state == mtap_pkg::capture_ir)
         ir_shift <= mtap_pkg::IR_CAPTURE;
      else if (state == mtap_pkg::shift_ir)
         ir_shift <= {ftap_tdi, ir_shift[mtap_pkg::IR_WIDTH-1:1]};
   end

   assign ir_tdo = ir_shift[0];

   // ****************************************
   // Decode with security gating
   // ****************************************
   // Restricted opcodes fall back to bypass when their feature is off
   always_comb
   begin
      case (ir_shift)
         mtap_pkg::OP_IDCODE:     decoded = mtap_pkg::instr_idcode;
         mtap_pkg::OP_DEBUG_CTRL: decoded = policy.feature_en[mtap_pkg::FEATURE_DEBUG] ?
                                            mtap_pkg::instr_debug_ctrl : mtap_pkg::instr_bypass;
         mtap_pkg::OP_SCAN_CFG:   decoded = policy.feature_en[mtap_pkg::FEATURE_SCAN] ?
                                            mtap_pkg::instr_scan_cfg : mtap_pkg::instr_bypass;
         mtap_pkg::OP_BYPASS:     decoded = mtap_pkg::instr_bypass;
         default:                 decoded = mtap_pkg::instr_bypass;
      endcase
   end

   // Update stage holds its decode until the next update_ir
   always_ff @(posedge ftap_tck)
   begin
      if (reset)
         instr <= mtap_pkg::instr_idcode;
      else if (state == mtap_pkg::test_logic_reset)
         instr <= mtap_pkg::instr_idcode;
      else if (state == mtap_pkg::update_ir)
         instr <= decoded;
   end

   // Debug control must not unlock while feature 0 is off at update time
   assert property (@(posedge ftap_tck) disable iff (reset)
      (state == mtap_pkg::update_ir && !policy.feature_en[mtap_pkg::FEATURE_DEBUG])
      |=> (instr != mtap_pkg::instr_debug_ctrl));

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the mTAP testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
   -f compile.f --top-module tb_mtap -Mdir obj_dir -o tb_mtap
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/tb_mtap > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "TEST FAILED" sim.log; then
   exit 1
fi
exit 0

/* source/mtap_dfxsecure.sv */
// ****************************************
// mTAP DFx security policy decoder
// Policy and straps to feature enables
// ****************************************
`timescale 1ns/1ns
`default_nettype none

module mtap_dfxsecure
   (
   input  mtap_pkg::secure_t                              ftap_dfxsecure,
   input  mtap_pkg::secure_t [mtap_pkg::NUM_FEATURES-1:0] dfxsecurestrap_feature,
   output mtap_pkg::secure_t                              atap_dfxsecure,
   mtap_policy_if.decoder                                 policy
   );

   logic                 all_en;
   logic                 all_dis;
   mtap_pkg::feature_t   feature_raw;
   mtap_pkg::feature_t   feature_en;

   // Policy passes straight through
   assign atap_dfxsecure = ftap_dfxsecure;

   // ****************************************
   // Policy extremes
   // ****************************************
   assign all_en  = (ftap_dfxsecure == '1);
   assign all_dis = (ftap_dfxsecure == '0);

   // Debug feature needs the low policy bits to match a 01 strap
   assign feature_raw[mtap_pkg::FEATURE_DEBUG] =
      (ftap_dfxsecure[1:0] == dfxsecurestrap_feature[mtap_pkg::FEATURE_DEBUG][1:0]) &&
      (dfxsecurestrap_feature[mtap_pkg::FEATURE_DEBUG][1:0] == mtap_pkg::DEBUG_STRAP_CODE);

   // Reserved slot
   assign feature_raw[1] = 1'b0;

   // Scan feature opens on any shared set bit
   assign feature_raw[mtap_pkg::FEATURE_SCAN] =
      |(ftap_dfxsecure & dfxsecurestrap_feature[mtap_pkg::FEATURE_SCAN]);

   // All-enable forces on, all-disable suppresses
   always_comb
   begin
      feature_en = '0;
      feature_en[mtap_pkg::FEATURE_DEBUG] =
         (feature_raw[mtap_pkg::FEATURE_DEBUG] && !all_dis) || all_en;
      feature_en[mtap_pkg::FEATURE_SCAN] =
         (feature_raw[mtap_pkg::FEATURE_SCAN] && !all_dis) || all_en;
   end

   // ****************************************
   // Outputs to the bundle
   // ****************************************
   assign policy.all_en     = all_en;
   assign policy.all_dis    = all_dis;
   assign policy.feature_en = feature_en;

   // Visibility disables keyed off the debug feature
   assign policy.vodfv_customer_dis = all_dis || !all_en || !feature_en[mtap_pkg::FEATURE_DEBUG];
   assign policy.vodfv_all_dis      = all_dis || (!all_en && !feature_en[mtap_pkg::FEATURE_DEBUG]);

   // Full enable and full disable are exclusive
   always_comb
   begin
      assert (!(all_en && all_dis));
   end

endmodule

`default_nettype wire

/* source/mtap_top.sv */
// ****************************************
// mTAP top level
// TAP controller, registers and policy
// ****************************************
`timescale 1ns/1ns
`default_nettype none

module mtap_top
   (
   input  logic                                           ftap_tck,
   input  logic                                           reset,
   input  logic                                           ftap_tms,
   input  logic                                           ftap_tdi,
   input  mtap_pkg::secure_t                              ftap_dfxsecure,
   input  mtap_pkg::secure_t [mtap_pkg::NUM_FEATURES-1:0] dfxsecurestrap_feature,
   output logic                                           atap_tdo,
   output mtap_pkg::secure_t                              atap_dfxsecure,
   output mtap_pkg::ctrl_t                                debug_ctrl,
   output mtap_pkg::ctrl_t                                scan_cfg,
   output logic                                           vodfv_all_dis,
   output logic                                           vodfv_customer_dis
   );

   mtap_pkg::tap_state_t   state;
   mtap_pkg::instr_t       instr;
   logic                   ir_tdo;

   // Decoded policy shared by decoder and IR
   mtap_policy_if policy ();

   // ****************************************
   // Controller and registers
   // ****************************************
   mtap_fsm i_fsm (
      .ftap_tck (ftap_tck),
      .reset    (reset),
      .ftap_tms (ftap_tms),
      .state    (state)
   );

   mtap_ir i_ir (
      .ftap_tck (ftap_tck),
      .reset    (reset),
      .ftap_tdi (ftap_tdi),
      .state    (state),
      .policy   (policy),
      .instr    (instr),
      .ir_tdo   (ir_tdo)
   );

   mtap_dr i_dr (
      .ftap_tck   (ftap_tck),
      .reset      (reset),
      .ftap_tdi   (ftap_tdi),
      .state      (state),
      .instr      (instr),
      .ir_tdo     (ir_tdo),
      .debug_ctrl (debug_ctrl),
      .scan_cfg   (scan_cfg),
      .tdo        (atap_tdo)
   );

   // Security policy
   mtap_dfxsecure i_dfxsecure (
      .ftap_dfxsecure         (ftap_dfxsecure),
      .dfxsecurestrap_feature (dfxsecurestrap_feature),
      .atap_dfxsecure         (atap_dfxsecure),
      .policy                 (policy)
   );

   assign vodfv_all_dis      = policy.vodfv_all_dis;
   assign vodfv_customer_dis = policy.vodfv_customer_dis;

endmodule

`default_nettype wire

/* tests/tb_mtap.sv */
// ****************************************
// mTAP testbench
// Table-driven JTAG access under DFx policy
// ****************************************
`timescale 1ns/1ns
`default_nettype none

module tb_mtap;

   localparam int NUM_TESTS      = 11;
   localparam int TIMEOUT_CYCLES = NUM_TESTS * 120 + 200;

   // One row per policy and instruction case
   typedef struct packed {
      mtap_pkg::secure_t   policy;
      mtap_pkg::secure_t   strap0;
      mtap_pkg::secure_t   strap2;
      mtap_pkg::ir_t       opcode;
   } entry_t;

   logic                                           ftap_tck;
   logic                                           reset;
   logic                                           ftap_tms;
   logic                                           ftap_tdi;
   mtap_pkg::secure_t                              ftap_dfxsecure;
   mtap_pkg::secure_t [mtap_pkg::NUM_FEATURES-1:0] dfxsecurestrap_feature;
   logic                                           atap_tdo;
   mtap_pkg::secure_t                              atap_dfxsecure;
   mtap_pkg::ctrl_t                                debug_ctrl;
   mtap_pkg::ctrl_t                                scan_cfg;
   logic                                           vodfv_all_dis;
   logic                                           vodfv_customer_dis;

   entry_t            tests [0:NUM_TESTS-1];
   mtap_pkg::ctrl_t   model_debug;
   mtap_pkg::ctrl_t   model_scan;
   integer            seed = 32681;
   int                cycle_count = 0;
   int                error_count = 0;
   int                failed_tests = 0;

   mtap_top i_dut (
      .ftap_tck               (ftap_tck),
      .reset                  (reset),
      .ftap_tms               (ftap_tms),
      .ftap_tdi               (ftap_tdi),
      .ftap_dfxsecure         (ftap_dfxsecure),
      .dfxsecurestrap_feature (dfxsecurestrap_feature),
      .atap_tdo               (atap_tdo),
      .atap_dfxsecure         (atap_dfxsecure),
      .debug_ctrl             (debug_ctrl),
      .scan_cfg               (scan_cfg),
      .vodfv_all_dis          (vodfv_all_dis),
      .vodfv_customer_dis     (vodfv_customer_dis)
   );

   initial
   begin
      ftap_tck = 1'b0;
      forever #5 ftap_tck = ~ftap_tck;
   end

   // Run limit from the table length
   always @(posedge ftap_tck)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("TEST FAILED");
         $finish;
      end
   end

   // ****************************************
   // Expected values from the policy rules
   // ****************************************
   function automatic logic [2:0] feature_model(input mtap_pkg::secure_t pol,
                                                input mtap_pkg::secure_t s0,
                                                input mtap_pkg::secure_t s2);
      logic en_all;
      logic dis_all;
      logic f0;
      logic f2;
      en_all  = (pol == 4'hF);
      dis_all = (pol == 4'h0);
      f0 = (pol[1:0] == s0[1:0]) && (s0[1:0] == 2'b01);
      f2 = ((pol & s2) != 4'h0);
      f0 = (f0 && !dis_all) || en_all;
      f2 = (f2 && !dis_all) || en_all;
      return {f2, 1'b0, f0};
   endfunction

   // Bit 1 is vodfv_all_dis, bit 0 is vodfv_customer_dis
   function automatic logic [1:0] visibility_model(input mtap_pkg::secure_t pol,
                                                   input mtap_pkg::secure_t s0);
      logic [2:0] feat;
      logic       en_all;
      logic       dis_all;
      feat    = feature_model(pol, s0, 4'h0);
      en_all  = (pol == 4'hF);
      dis_all = (pol == 4'h0);
      return {dis_all || (!en_all && !feat[0]), dis_all || !en_all || !feat[0]};
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
         error_count++;
      end
   endtask

   // ****************************************
   // JTAG driver tasks
   // ****************************************
   // One TCK cycle, TDO sampled mid-cycle while stable
   task automatic step(input logic tms, input logic tdi, output logic tdo_bit);
      ftap_tms = tms;
      ftap_tdi = tdi;
      #4;
      tdo_bit = atap_tdo;
      @(posedge ftap_tck);
      #1;
   endtask

   // From run_test_idle through an IR scan and back
   task automatic shift_ir(input mtap_pkg::ir_t op, output mtap_pkg::ir_t captured);
      logic b;
      step(1'b1, 1'b0, b);
      step(1'b1, 1'b0, b);
      step(1'b0, 1'b0, b);
      step(1'b0, 1'b0, b);
      for (int i = 0; i < mtap_pkg::IR_WIDTH; i++)
      begin
         step(i == mtap_pkg::IR_WIDTH - 1, op[i], b);
         captured[i] = b;
      end
      // Exit1 to update_ir, then the edge that loads the instruction
      step(1'b1, 1'b0, b);
      step(1'b0, 1'b0, b);
   endtask

   task automatic shift_dr(input int len, input logic [31:0] din, output logic [31:0] dout);
      logic b;
      dout = '0;
      step(1'b1, 1'b0, b);
      step(1'b0, 1'b0, b);
      step(1'b0, 1'b0, b);
      for (int i = 0; i < len; i++)
      begin
         step(i == len - 1, din[i], b);
         dout[i] = b;
      end
      step(1'b1, 1'b0, b);
      step(1'b0, 1'b0, b);
   endtask

   task automatic run_entry(input int idx);
      entry_t          e;
      logic [31:0]     rnd;
      mtap_pkg::ctrl_t wdata;
      mtap_pkg::ir_t   ir_out;
      logic [31:0]     dr_out;
      logic [8:0]      pat;
      logic [1:0]      vis;
      logic [2:0]      feat;
      logic            access;
      logic            b;
      int              errs_before;
      e = tests[idx];
      errs_before = error_count;
      rnd = $random(seed);
      wdata = rnd[7:0];
      ftap_dfxsecure = e.policy;
      dfxsecurestrap_feature[0] = e.strap0;
      dfxsecurestrap_feature[1] = 4'h0;
      dfxsecurestrap_feature[2] = e.strap2;
      step(1'b0, 1'b0, b);
      vis = visibility_model(e.policy, e.strap0);
      check("atap_dfxsecure", 32'(atap_dfxsecure), 32'(e.policy));
      check("vodfv_all_dis", 32'(vodfv_all_dis), 32'(vis[1]));
      check("vodfv_customer_dis", 32'(vodfv_customer_dis), 32'(vis[0]));
      // Restricted opcodes reach their register only when the feature is on
      feat = feature_model(e.policy, e.strap0, e.strap2);
      access = ((e.opcode == mtap_pkg::OP_DEBUG_CTRL) && feat[mtap_pkg::FEATURE_DEBUG]) ||
               ((e.opcode == mtap_pkg::OP_SCAN_CFG) && feat[mtap_pkg::FEATURE_SCAN]);
      shift_ir(e.opcode, ir_out);
      check("ir_capture", 32'(ir_out), 32'(mtap_pkg::IR_CAPTURE));
      if (access)
      begin
         // First scan reads the old value and writes the new one
         shift_dr(mtap_pkg::CTRL_WIDTH, 32'(wdata), dr_out);
         if (e.opcode == mtap_pkg::OP_DEBUG_CTRL)
         begin
            check("debug_ctrl_capture", dr_out, 32'(model_debug));
            model_debug = wdata;
         end
         else
         begin
            check("scan_cfg_capture", dr_out, 32'(model_scan));
            model_scan = wdata;
         end
         shift_dr(mtap_pkg::CTRL_WIDTH, 32'(wdata), dr_out);
         check("ctrl_readback", dr_out, 32'(wdata));
      end
      else
      begin
         // Bypass delays by one bit with a 0 in front
         pat = {wdata, 1'b1};
         shift_dr(9, 32'(pat), dr_out);
         check("bypass_out", dr_out, 32'({pat[7:0], 1'b0}));
      end
      check("debug_ctrl", 32'(debug_ctrl), 32'(model_debug));
      check("scan_cfg", 32'(scan_cfg), 32'(model_scan));
      if (error_count > errs_before)
         failed_tests++;
      $display("test %0d policy 0x%0h opcode 0x%0h: %s", idx, e.policy, e.opcode,
               (error_count > errs_before) ? "fail" : "pass");
   endtask

   // IDCODE read after either kind of reset
   task automatic idcode_read(input string label);
      logic [31:0] dr_out;
      int          errs_before;
      errs_before = error_count;
      shift_dr(32, 32'h0, dr_out);
      check("idcode", dr_out, mtap_pkg::IDCODE_VALUE);
      check("debug_ctrl", 32'(debug_ctrl), 32'(model_debug));
      check("scan_cfg", 32'(scan_cfg), 32'(model_scan));
      if (error_count > errs_before)
         failed_tests++;
      $display("test %s: %s", label, (error_count > errs_before) ? "fail" : "pass");
   endtask

   // ****************************************
   // Main sequence
   // ****************************************
   initial
   begin
      logic b;
      reset = 1'b1;
      ftap_tms = 1'b1;
      ftap_tdi = 1'b0;
      ftap_dfxsecure = 4'h0;
      dfxsecurestrap_feature = '0;
      model_debug = '0;
      model_scan = '0;
      // policy, strap 0, strap 2, opcode
      tests = '{
         '{4'h5, 4'h1, 4'h0, 4'h8},
         '{4'h6, 4'h1, 4'h0, 4'h8},
         '{4'h0, 4'h1, 4'hF, 4'h8},
         '{4'hF, 4'h0, 4'h0, 4'h9},
         '{4'h4, 4'h0, 4'h4, 4'h9},
         '{4'h2, 4'h0, 4'h4, 4'h9},
         '{4'h0, 4'h0, 4'hF, 4'h9},
         '{4'h5, 4'h1, 4'h0, 4'hF},
         '{4'hF, 4'h0, 4'h0, 4'h3},
         '{4'h9, 4'h1, 4'h0, 4'h8},
         '{4'hF, 4'h0, 4'h0, 4'h8}
      };
      repeat (8) @(posedge ftap_tck);
      #1;
      reset = 1'b0;
      step(1'b0, 1'b0, b);
      idcode_read("reset_idcode");
      for (int i = 0; i < NUM_TESTS; i++)
         run_entry(i);
      // Five TMS-high edges, then back to idle
      repeat (5) step(1'b1, 1'b0, b);
      step(1'b0, 1'b0, b);
      idcode_read("tms_reset_idcode");
      $display("tests run %0d, failed %0d, errors %0d", NUM_TESTS + 2, failed_tests,
               error_count);
      if (error_count == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire
